// File: include/crc_config.svh
// Build-time configuration of the CRC accelerator
// Buffer depth and register reset values
`ifndef CRC_CONFIG_SVH
`define CRC_CONFIG_SVH

////////////////////////////////////////
// Data buffer
////////////////////////////////////////

// Number of data words held between the bus and the engine
`define CRC_BUF_DEPTH 4

////////////////////////////////////////
// Register reset values
////////////////////////////////////////

// Initial CRC value, also the CRC state right after reset
`define CRC_INIT_RESET 32'hFFFF_FFFF

// Default polynomial is the Ethernet CRC-32
`define CRC_POLY_RESET 32'h04C1_1DB7

// Stored control bits: poly size, input and output reversal
// Zero selects a 32-bit CRC with no reversal
`define CRC_CR_RESET 5'h00

// Scratch byte starts cleared
`define CRC_IDR_RESET 8'h00

`endif

// File: design/crc_pkg.sv
// Shared types of the CRC accelerator
// Bus transfer type, register map, CRC configuration and engine FSM states
`default_nettype none

package crc_pkg;

	// AHB transfer type, HTRANS encoding
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// Word offsets from HADDR[4:2]
	typedef enum logic [2:0] {
		CRC_DR   = 3'h0,
		CRC_IDR  = 3'h1,
		CRC_CR   = 3'h2,
		CRC_INIT = 3'h4,
		CRC_POL  = 3'h5
	} crc_reg_t;

	// CRC width, also picks the output mask
	typedef enum logic [1:0] {
		P32 = 2'b00,
		P16 = 2'b01,
		P8  = 2'b10,
		P7  = 2'b11
	} poly_size_t;

	// Span of the input bit reversal
	typedef enum logic [1:0] {
		NO_REV   = 2'b00,
		REV_BYTE = 2'b01,
		REV_HALF = 2'b10,
		REV_WORD = 2'b11
	} rev_in_t;

	// Engine FSM
	typedef enum logic [1:0] {
		ENG_IDLE  = 2'b00,
		ENG_SHIFT = 2'b01,
		ENG_LOAD  = 2'b10
	} engine_state_t;

endpackage

`default_nettype wire

// File: design/host_interface.sv
// AHB-Lite slave of the CRC accelerator
// Address-phase pipeline, register decode, control register, wait states, read mux
`default_nettype none
`include "crc_config.svh"

module host_interface
(
	// AHB slave port
	input  wire logic                HCLK,
	input  wire logic                HRESETn,
	input  wire logic                HSElx,
	input  wire logic                HREADY,
	input  wire logic                HWRITE,
	input  wire logic [31:0]         HADDR,
	input  wire logic [31:0]         HWDATA,
	input  wire logic [1:0]          HTRANS,
	input  wire logic [2:0]          HSIZE,
	output logic [31:0]              HRDATA,
	output logic                     HREADYOUT,
	output logic                     HRESP,
	// Toward buffer and engine
	output logic [31:0]              bus_wr,
	output logic [1:0]               bus_size,
	output crc_pkg::poly_size_t      crc_poly_size,
	output crc_pkg::rev_in_t         rev_in_type,
	output logic                     rev_out_type,
	output logic                     crc_init_en,
	output logic                     crc_idr_en,
	output logic                     crc_poly_en,
	output logic                     buffer_write_en,
	output logic                     reset_chain,
	// Read-back and status
	input  wire logic [31:0]         crc_out,
	input  wire logic [31:0]         crc_init_out,
	input  wire logic [31:0]         crc_poly_out,
	input  wire logic [7:0]          crc_idr_out,
	input  wire logic                buffer_full,
	input  wire logic                reset_pending,
	input  wire logic                read_wait
);

	// Address-phase pipeline
	crc_pkg::crc_reg_t haddr_pp;
	crc_pkg::htrans_t  htrans_pp;
	logic [1:0]        hsize_pp;
	logic              hwrite_pp;
	logic              hselx_pp;

	// Stored control bits {rev_out, rev_in[1:0], poly_size[1:0]}
	logic [4:0]  crc_cr_ff;
	logic [31:0] crc_cr_rd;

	logic sample_bus;
	logic ahb_enable;
	logic write_en;
	logic read_en;
	logic dr_write;
	logic dr_read;
	logic init_write;
	logic crc_cr_en;

	////////////////////////////////////////
	// Address phase
	////////////////////////////////////////

	// New address phase only when the previous data phase completes
	assign sample_bus = HREADYOUT && HREADY;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp <= 1'b0;
		end
		else if (sample_bus)
		begin
			haddr_pp  <= crc_pkg::crc_reg_t'(HADDR[4:2]);
			htrans_pp <= crc_pkg::htrans_t'(HTRANS);
			// Sizes up to a word only
			hsize_pp  <= HSIZE[1:0];
			hwrite_pp <= HWRITE;
			hselx_pp  <= HSElx;
		end
	end

	////////////////////////////////////////
	// Decode and strobes
	////////////////////////////////////////

	// SEQ and BUSY beats are ignored
	assign ahb_enable = (htrans_pp == crc_pkg::NONSEQ);
	assign write_en   = hselx_pp && hwrite_pp && ahb_enable;
	assign read_en    = hselx_pp && !hwrite_pp && ahb_enable;

	assign dr_write   = write_en && (haddr_pp == crc_pkg::CRC_DR);
	assign dr_read    = read_en && (haddr_pp == crc_pkg::CRC_DR);
	assign init_write = write_en && (haddr_pp == crc_pkg::CRC_INIT);

	// Data words also wait while a restart is pending so they land in the new chain
	assign buffer_write_en = dr_write && !buffer_full && !reset_pending;
	// Init load waits until the pending restart has used the old value
	assign crc_init_en = init_write && !reset_pending;
	assign crc_idr_en  = write_en && (haddr_pp == crc_pkg::CRC_IDR);
	assign crc_poly_en = write_en && (haddr_pp == crc_pkg::CRC_POL);
	assign crc_cr_en   = write_en && (haddr_pp == crc_pkg::CRC_CR);

	// Write data is taken straight from the data phase
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	// Wait states
	assign HREADYOUT = !((dr_write && (buffer_full || reset_pending)) ||
	                     (dr_read && read_wait) ||
	                     (init_write && reset_pending));

	// Never an error response
	assign HRESP = 1'b0;

	////////////////////////////////////////
	// Control register
	////////////////////////////////////////

	// Bit 0 is a self-clearing restart, bits 7:3 are stored
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_cr_ff <= `CRC_CR_RESET;
		else if (crc_cr_en)
			crc_cr_ff <= HWDATA[7:3];
	end

	assign reset_chain   = crc_cr_en && HWDATA[0];
	assign crc_poly_size = crc_pkg::poly_size_t'(crc_cr_ff[1:0]);
	assign rev_in_type   = crc_pkg::rev_in_t'(crc_cr_ff[3:2]);
	assign rev_out_type  = crc_cr_ff[4];

	// Read view keeps the stored bits at their write position
	assign crc_cr_rd = {24'h0, crc_cr_ff, 3'h0};

	// Read mux, unmapped offsets read as zero
	always_comb
	begin
		case (haddr_pp)
			crc_pkg::CRC_DR:   HRDATA = crc_out;
			crc_pkg::CRC_IDR:  HRDATA = {24'h0, crc_idr_out};
			crc_pkg::CRC_CR:   HRDATA = crc_cr_rd;
			crc_pkg::CRC_INIT: HRDATA = crc_init_out;
			crc_pkg::CRC_POL:  HRDATA = crc_poly_out;
			default:           HRDATA = 32'h0;
		endcase
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Register loads happen only on the edge that completes their data phase
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(buffer_write_en || crc_init_en || crc_idr_en || crc_poly_en || crc_cr_en)
		|-> HREADYOUT);

	// A stalled data read is released once the engine catches up
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(dr_read && read_wait) |-> ##[1:32] HREADYOUT);

endmodule

`default_nettype wire

// File: design/crc_data_buffer.sv
// Data word FIFO between the bus and the CRC engine
// Circular buffer of words with their transfer size, valid/ready toward the engine
`default_nettype none
`include "crc_config.svh"

module crc_data_buffer
(
	input  wire logic        HCLK,
	input  wire logic        HRESETn,
	input  wire logic        buffer_write_en,
	input  wire logic [31:0] bus_wr,
	input  wire logic [1:0]  bus_size,
	input  wire logic        word_ready,
	output logic             buffer_full,
	output logic             word_valid,
	output logic [31:0]      word_data,
	output logic [1:0]       word_size
);

	localparam int DEPTH = `CRC_BUF_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Storage
	logic [31:0] data_mem [DEPTH];
	logic [1:0]  size_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign push = buffer_write_en;
	assign pop  = word_valid && word_ready;

	always_ff @(posedge HCLK)
	begin
		if (push)
		begin
			data_mem[wr_ptr] <= bus_wr;
			size_mem[wr_ptr] <= bus_size;
		end
	end

	// Pointers wrap at the depth, count tracks simultaneous push and pop
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign buffer_full = (count == CNT_W'(DEPTH));
	assign word_valid  = (count != '0);
	// Head entry offered to the engine
	assign word_data   = data_mem[rd_ptr];
	assign word_size   = size_mem[rd_ptr];

	// No push into a full buffer
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		buffer_write_en |-> !buffer_full);

endmodule

`default_nettype wire

// File: design/crc_engine.sv
// CRC engine with init, polynomial and IDR registers
// Input reversal, byte-serial CRC update, output masking and reversal
`default_nettype none
`include "crc_config.svh"

module crc_engine
(
	input  wire logic                HCLK,
	input  wire logic                HRESETn,
	// Word stream from the buffer
	input  wire logic                word_valid,
	input  wire logic [31:0]         word_data,
	input  wire logic [1:0]          word_size,
	output logic                     word_ready,
	// Register loads and configuration
	input  wire logic                crc_init_en,
	input  wire logic                crc_idr_en,
	input  wire logic                crc_poly_en,
	input  wire logic                reset_chain,
	input  wire logic [31:0]         bus_wr,
	input  wire crc_pkg::poly_size_t crc_poly_size,
	input  wire crc_pkg::rev_in_t    rev_in_type,
	input  wire logic                rev_out_type,
	// Status and read-back
	output logic                     engine_busy,
	output logic                     reset_pending,
	output logic [31:0]              crc_out,
	output logic [31:0]              crc_init_out,
	output logic [31:0]              crc_poly_out,
	output logic [7:0]               crc_idr_out
);

	crc_pkg::engine_state_t state;
	logic [31:0] crc_raw;
	logic [31:0] word_sr;
	logic [1:0]  byte_cnt;
	logic [31:0] crc_mask;
	logic [31:0] crc_masked;

	// Reversal span is clipped to the transfer size
	function automatic logic [31:0] reverse_in(input logic [31:0] data,
		input crc_pkg::rev_in_t mode, input logic [1:0] size);
		crc_pkg::rev_in_t span;
		logic [31:0] result;
		span = mode;
		if (size == 2'd0 && mode != crc_pkg::NO_REV)
			span = crc_pkg::REV_BYTE;
		else if (size == 2'd1 && mode == crc_pkg::REV_WORD)
			span = crc_pkg::REV_HALF;
		result = data;
		for (int i = 0; i < 32; i++)
		begin
			case (span)
				crc_pkg::REV_BYTE: result[i] = data[(i / 8) * 8 + 7 - (i % 8)];
				crc_pkg::REV_HALF: result[i] = data[(i / 16) * 16 + 15 - (i % 16)];
				crc_pkg::REV_WORD: result[i] = data[31 - i];
				default:           result[i] = data[i];
			endcase
		end
		return result;
	endfunction

	// One byte, MSB first, through a CRC whose width is given by the mask
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data,
		input logic [31:0] poly, input logic [31:0] mask);
		logic [31:0] c;
		logic [31:0] top;
		logic fb;
		c = crc & mask;
		top = mask & ~(mask >> 1);
		for (int i = 7; i >= 0; i--)
		begin
			fb = (|(c & top)) ^ data[i];
			c = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_init_out <= `CRC_INIT_RESET;
			crc_poly_out <= `CRC_POLY_RESET;
			crc_idr_out  <= `CRC_IDR_RESET;
		end
		else
		begin
			if (crc_init_en)
				crc_init_out <= bus_wr;
			if (crc_poly_en)
				crc_poly_out <= bus_wr;
			if (crc_idr_en)
				crc_idr_out <= bus_wr[7:0];
		end
	end

	// Restart request, cleared when the load is done
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			reset_pending <= 1'b0;
		else if (reset_chain)
			reset_pending <= 1'b1;
		else if (state == crc_pkg::ENG_LOAD)
			reset_pending <= 1'b0;
	end

	////////////////////////////////////////
	// Engine FSM
	////////////////////////////////////////

	// Buffered words drain first, the host holds new words while a restart pends
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state    <= crc_pkg::ENG_IDLE;
			byte_cnt <= 2'd0;
			crc_raw  <= `CRC_INIT_RESET;
		end
		else
		begin
			case (state)
				crc_pkg::ENG_IDLE:
				begin
					if (word_valid)
					begin
						word_sr  <= reverse_in(word_data, rev_in_type, word_size);
						// Bytes left after the first one
						byte_cnt <= (word_size == 2'd0) ? 2'd0 : (word_size == 2'd1) ? 2'd1 : 2'd3;
						state    <= crc_pkg::ENG_SHIFT;
					end
					else if (reset_pending)
						state <= crc_pkg::ENG_LOAD;
				end
				crc_pkg::ENG_SHIFT:
				begin
					// Least significant byte first
					crc_raw  <= crc_byte(crc_raw, word_sr[7:0], crc_poly_out, crc_mask);
					word_sr  <= word_sr >> 8;
					byte_cnt <= byte_cnt - 2'd1;
					if (byte_cnt == 2'd0)
						state <= crc_pkg::ENG_IDLE;
				end
				crc_pkg::ENG_LOAD:
				begin
					crc_raw <= crc_init_out;
					state   <= crc_pkg::ENG_IDLE;
				end
				default:
					state <= crc_pkg::ENG_IDLE;
			endcase
		end
	end

	assign word_ready  = (state == crc_pkg::ENG_IDLE);
	// A pending restart counts as work so data reads see the reloaded value
	assign engine_busy = (state != crc_pkg::ENG_IDLE) || reset_pending;

	////////////////////////////////////////
	// Output
	////////////////////////////////////////

	always_comb
	begin
		case (crc_poly_size)
			crc_pkg::P16: crc_mask = 32'h0000_FFFF;
			crc_pkg::P8:  crc_mask = 32'h0000_00FF;
			crc_pkg::P7:  crc_mask = 32'h0000_007F;
			default:      crc_mask = 32'hFFFF_FFFF;
		endcase
	end

	assign crc_masked = crc_raw & crc_mask;
	// Output reversal spans the full word
	assign crc_out = rev_out_type ? {<<{crc_masked}} : crc_masked;

	// A pending restart completes once the queued words have drained
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		$rose(reset_pending) |-> ##[1:32] !reset_pending);

endmodule

`default_nettype wire

// File: design/crc_ahb_top.sv
// Top level of the CRC accelerator
// AHB-Lite slave, data buffer and CRC engine in a chain
`default_nettype none

module crc_ahb_top
(
	input  wire logic        HCLK,
	input  wire logic        HRESETn,
	input  wire logic        HSElx,
	input  wire logic        HREADY,
	input  wire logic        HWRITE,
	input  wire logic [31:0] HADDR,
	input  wire logic [31:0] HWDATA,
	input  wire logic [1:0]  HTRANS,
	input  wire logic [2:0]  HSIZE,
	output logic [31:0]      HRDATA,
	output logic             HREADYOUT,
	output logic             HRESP
);

	// Host to buffer and engine
	logic [31:0] bus_wr;
	logic [1:0]  bus_size;
	crc_pkg::poly_size_t crc_poly_size;
	crc_pkg::rev_in_t    rev_in_type;
	logic rev_out_type;
	logic crc_init_en;
	logic crc_idr_en;
	logic crc_poly_en;
	logic buffer_write_en;
	logic reset_chain;

	// Buffer to engine
	logic        buffer_full;
	logic        word_valid;
	logic        word_ready;
	logic [31:0] word_data;
	logic [1:0]  word_size;

	// Engine back to host
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;
	logic        engine_busy;
	logic        reset_pending;
	logic        read_wait;

	// Data reads wait for queued words and engine activity
	assign read_wait = word_valid | engine_busy;

	host_interface i_host
	(
		.HCLK(HCLK), .HRESETn(HRESETn), .HSElx(HSElx), .HREADY(HREADY),
		.HWRITE(HWRITE), .HADDR(HADDR), .HWDATA(HWDATA), .HTRANS(HTRANS),
		.HSIZE(HSIZE), .HRDATA(HRDATA), .HREADYOUT(HREADYOUT), .HRESP(HRESP),
		.bus_wr(bus_wr), .bus_size(bus_size), .crc_poly_size(crc_poly_size),
		.rev_in_type(rev_in_type), .rev_out_type(rev_out_type),
		.crc_init_en(crc_init_en), .crc_idr_en(crc_idr_en), .crc_poly_en(crc_poly_en),
		.buffer_write_en(buffer_write_en), .reset_chain(reset_chain),
		.crc_out(crc_out), .crc_init_out(crc_init_out), .crc_poly_out(crc_poly_out),
		.crc_idr_out(crc_idr_out), .buffer_full(buffer_full),
		.reset_pending(reset_pending), .read_wait(read_wait)
	);

	crc_data_buffer i_buffer
	(
		.HCLK(HCLK), .HRESETn(HRESETn), .buffer_write_en(buffer_write_en),
		.bus_wr(bus_wr), .bus_size(bus_size), .word_ready(word_ready),
		.buffer_full(buffer_full), .word_valid(word_valid),
		.word_data(word_data), .word_size(word_size)
	);

	crc_engine i_engine
	(
		.HCLK(HCLK), .HRESETn(HRESETn), .word_valid(word_valid),
		.word_data(word_data), .word_size(word_size), .word_ready(word_ready),
		.crc_init_en(crc_init_en), .crc_idr_en(crc_idr_en), .crc_poly_en(crc_poly_en),
		.reset_chain(reset_chain), .bus_wr(bus_wr), .crc_poly_size(crc_poly_size),
		.rev_in_type(rev_in_type), .rev_out_type(rev_out_type),
		.engine_busy(engine_busy), .reset_pending(reset_pending), .crc_out(crc_out),
		.crc_init_out(crc_init_out), .crc_poly_out(crc_poly_out),
		.crc_idr_out(crc_idr_out)
	);

endmodule

`default_nettype wire

// File: tb/crc_checker.sv
// Bus monitor with a reference model of the CRC accelerator
// Follows completed AHB transfers, checks read data and counts errors
`default_nettype none
`include "crc_config.svh"

module crc_checker
(
	input  wire logic        HCLK,
	input  wire logic        HRESETn,
	input  wire logic        HSElx,
	input  wire logic        HREADY,
	input  wire logic        HREADYOUT,
	input  wire logic        HWRITE,
	input  wire logic [31:0] HADDR,
	input  wire logic [31:0] HWDATA,
	input  wire logic [1:0]  HTRANS,
	input  wire logic [2:0]  HSIZE,
	input  wire logic [31:0] HRDATA,
	input  wire logic        HRESP,
	output int               error_count,
	output int               read_count,
	output int               xfer_count
);

	// Register model
	logic [31:0] poly_m;
	logic [31:0] init_m;
	logic [31:0] crc_m;
	logic [7:0]  idr_m;
	logic [4:0]  cr_m;

	// Data phase in progress
	logic        dp_active;
	logic        dp_write;
	logic [2:0]  dp_offset;
	logic [1:0]  dp_size;
	logic [31:0] expected_rd;

	function automatic int crc_width(input logic [1:0] size_sel);
		case (size_sel)
			2'd1: return 16;
			2'd2: return 8;
			2'd3: return 7;
			default: return 32;
		endcase
	endfunction

	function automatic logic [31:0] width_mask(input int width);
		if (width == 32)
			return 32'hFFFF_FFFF;
		return (32'h1 << width) - 32'h1;
	endfunction

	// Chunks of the reversal span, never wider than the transfer itself
	function automatic logic [31:0] flip_input(input logic [31:0] data, input logic [1:0] mode,
		input logic [1:0] size);
		int nbits;
		int span;
		logic [31:0] out;
		nbits = 8 << size;
		span = (mode == 2'd0) ? 0 : (8 << (mode - 2'd1));
		if (span > nbits)
			span = nbits;
		out = data;
		if (span != 0)
		begin
			for (int i = 0; i < nbits; i++)
				out[(i / span) * span + span - 1 - (i % span)] = data[i];
		end
		return out;
	endfunction

	// Bitwise MSB-first CRC of the given width over one byte
	function automatic logic [31:0] fold_byte(input logic [31:0] crc, input logic [7:0] data,
		input logic [31:0] poly, input int width);
		logic [31:0] mask;
		logic [31:0] state;
		logic feedback;
		mask = width_mask(width);
		state = crc & mask;
		for (int b = 7; b >= 0; b--)
		begin
			feedback = state[width - 1] ^ data[b];
			state = (state << 1) & mask;
			if (feedback)
				state = state ^ (poly & mask);
		end
		return state;
	endfunction

	function automatic logic [31:0] expected_read(input logic [2:0] offset);
		logic [31:0] masked;
		logic [31:0] flipped;
		masked = crc_m & width_mask(crc_width(cr_m[1:0]));
		for (int i = 0; i < 32; i++)
			flipped[i] = masked[31 - i];
		case (offset)
			crc_pkg::CRC_DR:   return cr_m[4] ? flipped : masked;
			crc_pkg::CRC_IDR:  return {24'h0, idr_m};
			crc_pkg::CRC_CR:   return {24'h0, cr_m, 3'h0};
			crc_pkg::CRC_INIT: return init_m;
			crc_pkg::CRC_POL:  return poly_m;
			default:           return 32'h0;
		endcase
	endfunction

	task automatic apply_write(input logic [2:0] offset, input logic [1:0] size,
		input logic [31:0] data);
		logic [31:0] flipped;
		case (offset)
			crc_pkg::CRC_DR:
			begin
				// Low byte enters the CRC first
				flipped = flip_input(data, cr_m[3:2], size);
				for (int n = 0; n < (1 << size); n++)
					crc_m = fold_byte(crc_m, flipped[n * 8 +: 8], poly_m, crc_width(cr_m[1:0]));
			end
			crc_pkg::CRC_IDR:
				idr_m = data[7:0];
			crc_pkg::CRC_CR:
			begin
				cr_m = data[7:3];
				// Restart reloads the chain from the current init value
				if (data[0])
					crc_m = init_m;
			end
			crc_pkg::CRC_INIT:
				init_m = data;
			crc_pkg::CRC_POL:
				poly_m = data;
			default:
				cr_m = cr_m;
		endcase
	endtask

	always @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			poly_m      = `CRC_POLY_RESET;
			init_m      = `CRC_INIT_RESET;
			crc_m       = `CRC_INIT_RESET;
			idr_m       = `CRC_IDR_RESET;
			cr_m        = `CRC_CR_RESET;
			dp_active   = 1'b0;
			error_count = 0;
			read_count  = 0;
			xfer_count  = 0;
		end
		else
		begin
			// Data phase ends on an edge with HREADYOUT high
			if (dp_active && HREADYOUT)
			begin
				xfer_count++;
				if (HRESP != 1'b0)
				begin
					$display("Error: HRESP expected 0x0, actual 0x%0h", HRESP);
					error_count++;
				end
				if (dp_write)
					apply_write(dp_offset, dp_size, HWDATA);
				else
				begin
					expected_rd = expected_read(dp_offset);
					read_count++;
					if (HRDATA !== expected_rd)
					begin
						$display("Error: HRDATA at offset %0d expected 0x%08h, actual 0x%08h",
							dp_offset, expected_rd, HRDATA);
						error_count++;
					end
				end
				dp_active = 1'b0;
			end
			// Only selected NONSEQ beats touch the model
			if (HREADY && HREADYOUT)
			begin
				dp_active = HSElx && (HTRANS == crc_pkg::NONSEQ);
				dp_write  = HWRITE;
				dp_offset = HADDR[4:2];
				dp_size   = HSIZE[1:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_crc_ahb.sv
// Testbench top of the CRC accelerator
// Clock, reset, random AHB master, watchdog and final report
`default_nettype none

module tb_crc_ahb;

	localparam int NUM_OPS = 400;
	// Longest op is a burst of 8 writes, the reset reads come on top
	localparam int MAX_XFERS = NUM_OPS * 8 + 16;
	localparam int TIMEOUT_CYCLES = MAX_XFERS * 20 + 10;
	localparam logic [31:0] SEED = 32'h37c592d9;

	logic        HCLK;
	logic        HRESETn;
	logic        HSElx;
	logic        HWRITE;
	logic [31:0] HADDR;
	logic [31:0] HWDATA;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	wire logic        HREADY;
	wire logic [31:0] HRDATA;
	wire logic        HREADYOUT;
	wire logic        HRESP;

	logic [31:0] lcg_state;
	// Stored CR bits as last written by the master
	logic [4:0]  cur_cr;
	int n_issued;
	int error_count;
	int read_count;
	int xfer_count;

	// Only slave on the bus, so HREADY follows its own HREADYOUT
	assign HREADY = HREADYOUT;

	crc_ahb_top i_dut
	(
		.HCLK(HCLK), .HRESETn(HRESETn), .HSElx(HSElx), .HREADY(HREADY),
		.HWRITE(HWRITE), .HADDR(HADDR), .HWDATA(HWDATA), .HTRANS(HTRANS),
		.HSIZE(HSIZE), .HRDATA(HRDATA), .HREADYOUT(HREADYOUT), .HRESP(HRESP)
	);

	crc_checker i_checker
	(
		.HCLK(HCLK), .HRESETn(HRESETn), .HSElx(HSElx), .HREADY(HREADY),
		.HREADYOUT(HREADYOUT), .HWRITE(HWRITE), .HADDR(HADDR), .HWDATA(HWDATA),
		.HTRANS(HTRANS), .HSIZE(HSIZE), .HRDATA(HRDATA), .HRESP(HRESP),
		.error_count(error_count), .read_count(read_count), .xfer_count(xfer_count)
	);

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// Numerical Recipes LCG constants
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Byte, half-word or word, from the upper bits
	function automatic logic [1:0] rand_size();
		logic [31:0] r;
		r = lcg_next();
		return 2'((r >> 16) % 32'd3);
	endfunction

	// Address phase, then data phase until HREADYOUT is high
	task automatic bus_transfer(input logic sel, input logic [1:0] trans, input logic wr,
		input logic [2:0] offset, input logic [1:0] size, input logic [31:0] wdata);
		HSElx  <= sel;
		HTRANS <= trans;
		HWRITE <= wr;
		HADDR  <= {27'h0, offset, 2'b00};
		HSIZE  <= {1'b0, size};
		if (sel && trans == 2'b10)
			n_issued++;
		@(posedge HCLK);
		// Address bus idles during the data phase
		HSElx  <= 1'b0;
		HTRANS <= 2'b00;
		HWDATA <= wdata;
		do
			@(posedge HCLK);
		while (!HREADYOUT);
	endtask

	task automatic write_reg(input logic [2:0] offset, input logic [31:0] data);
		bus_transfer(1'b1, crc_pkg::NONSEQ, 1'b1, offset, 2'd2, data);
	endtask

	task automatic read_reg(input logic [2:0] offset);
		bus_transfer(1'b1, crc_pkg::NONSEQ, 1'b0, offset, 2'd2, 32'h0);
	endtask

	task automatic run_random_op();
		logic [31:0] pick;
		logic [31:0] value;
		logic [31:0] word;
		logic [1:0]  size;
		logic [1:0]  trans;
		int burst_len;
		pick  = lcg_next();
		value = lcg_next();
		case (pick[31:28])
			4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
				bus_transfer(1'b1, crc_pkg::NONSEQ, 1'b1, crc_pkg::CRC_DR, rand_size(), value);
			4'd5:
			begin
				// Longer than the buffer so the slave has to stall
				burst_len = 5 + int'(pick[27:26]);
				for (int n = 0; n < burst_len; n++)
				begin
					size = rand_size();
					word = lcg_next();
					bus_transfer(1'b1, crc_pkg::NONSEQ, 1'b1, crc_pkg::CRC_DR, size, word);
				end
			end
			4'd6, 4'd7:
				read_reg(crc_pkg::CRC_DR);
			4'd8:
			begin
				// Drain, then new width and reversal; bit 0 may restart
				read_reg(crc_pkg::CRC_DR);
				write_reg(crc_pkg::CRC_CR, {24'h0, value[31:24]});
				cur_cr = value[31:27];
			end
			4'd9:
			begin
				read_reg(crc_pkg::CRC_DR);
				write_reg(crc_pkg::CRC_POL, value);
			end
			4'd10:
				write_reg(crc_pkg::CRC_INIT, value);
			4'd11:
				write_reg(crc_pkg::CRC_IDR, value);
			4'd12:
			begin
				case (pick[27:26])
					2'd0: read_reg(crc_pkg::CRC_POL);
					2'd1: read_reg(crc_pkg::CRC_INIT);
					2'd2: read_reg(crc_pkg::CRC_IDR);
					default: read_reg(crc_pkg::CRC_CR);
				endcase
			end
			4'd13:
			begin
				// Chain restart with the configuration kept
				read_reg(crc_pkg::CRC_DR);
				write_reg(crc_pkg::CRC_CR, {24'h0, cur_cr, 3'b001});
			end
			4'd14:
			begin
				// IDLE, BUSY or SEQ beat, selected
				trans = (pick[27:26] == 2'b10) ? 2'b11 : pick[27:26];
				bus_transfer(1'b1, trans, pick[25], pick[24:22], rand_size(), value);
			end
			default:
				bus_transfer(1'b0, crc_pkg::NONSEQ, pick[25], pick[24:22], rand_size(), value);
		endcase
	endtask

	task automatic report_result();
		int total;
		total = error_count;
		if (xfer_count != n_issued)
		begin
			$display("Transfer count mismatch: %0d issued but %0d completed", n_issued,
				xfer_count);
			total++;
		end
		$display("Errors: %0d, reads checked: %0d, transfers: %0d", total, read_count,
			xfer_count);
		if (total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	////////////////////////////////////////
	// Clock, main sequence, watchdog
	////////////////////////////////////////

	initial
	begin
		HCLK = 1'b0;
		forever
			#2 HCLK = ~HCLK;
	end

	initial
	begin
		lcg_state = SEED;
		cur_cr    = 5'h00;
		n_issued  = 0;
		HRESETn <= 1'b0;
		HSElx   <= 1'b0;
		HWRITE  <= 1'b0;
		HADDR   <= 32'h0;
		HWDATA  <= 32'h0;
		HTRANS  <= 2'b00;
		HSIZE   <= 3'b000;
		repeat (10)
			@(posedge HCLK);
		HRESETn <= 1'b1;
		@(posedge HCLK);
		// Reset values before any write
		read_reg(crc_pkg::CRC_POL);
		read_reg(crc_pkg::CRC_INIT);
		read_reg(crc_pkg::CRC_IDR);
		read_reg(crc_pkg::CRC_CR);
		read_reg(crc_pkg::CRC_DR);
		for (int op = 0; op < NUM_OPS; op++)
			run_random_op();
		// Final read covers every word still in flight
		read_reg(crc_pkg::CRC_DR);
		// Let the monitor finish the last transfer
		repeat (2)
			@(posedge HCLK);
		report_result();
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES)
			@(posedge HCLK);
		$display("Timeout: bus master did not finish %0d operations in %0d cycles", NUM_OPS,
			TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
design/crc_pkg.sv
design/host_interface.sv
design/crc_data_buffer.sv
design/crc_engine.sv
design/crc_ahb_top.sv
tb/crc_checker.sv
tb/tb_crc_ahb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the CRC accelerator testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_crc_ahb -o sim_crc \
	&& ./obj_dir/sim_crc > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log 2>/dev/null && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
